// ==== aluUnit.sv ====
`timescale 1ns/1ps
module aluUnit (
    input  logic [cpuPkg::dataWidth-1:0] yVal,
    input  logic [cpuPkg::dataWidth-1:0] busVal,
    input  cpuPkg::aluOpT aluOp,
    input  logic incPc,
    output logic [cpuPkg::dataWidth-1:0] result
);
    import cpuPkg::*;

    logic [shiftWidth-1:0] shamt;

    assign shamt = busVal[shiftWidth-1:0];  // Shift count from the bus operand.

    always_comb begin
        if (incPc) begin
            result = busVal + 1'b1;  // PC increment during fetch.
        end else begin
            case (aluOp)
                aluAdd: begin
                    result = yVal + busVal;
                end
                aluSub: begin
                    result = yVal - busVal;
                end
                aluAnd: begin
                    result = yVal & busVal;
                end
                aluOr: begin
                    result = yVal | busVal;
                end
                aluShl: begin
                    result = yVal << shamt;
                end
                aluShr: begin
                    result = yVal >> shamt;  // Logical shift.
                end
                default: begin
                    result = busVal;  // Pass-through.
                end
            endcase
        end
    end

endmodule

// ==== busRegs.sv ====
`timescale 1ns/1ps
module busRegs (
    input  logic clk,
    input  logic rstN,
    input  cpuPkg::ctrlSignals ctrl,
    input  logic [cpuPkg::dataWidth-1:0] regData,
    input  logic [cpuPkg::dataWidth-1:0] mdrData,
    input  logic [cpuPkg::dataWidth-1:0] aluResult,
    output logic [cpuPkg::dataWidth-1:0] busVal,
    output logic [cpuPkg::dataWidth-1:0] yVal,
    output cpuPkg::instrWord instr
);
    import cpuPkg::*;

    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] z;
    logic [dataWidth-1:0] constExt;

    // Sign-extend the immediate field of IR.
    assign constExt = {{(dataWidth - constWidth){instr.iFmt.c[constWidth-1]}}, instr.iFmt.c};

    // Only one source is enabled per cycle; idle bus reads as zero.
    always_comb begin
        busVal = '0;
        if (|ctrl.regOut) begin
            busVal = regData;
        end else if (ctrl.pcOut) begin
            busVal = pc;
        end else if (ctrl.zOut) begin
            busVal = z;
        end else if (ctrl.mdrOut) begin
            busVal = mdrData;
        end else if (ctrl.cOut) begin
            busVal = constExt;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else if (ctrl.pcIn) begin
            pc <= busVal;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.irIn) instr <= busVal;
        if (ctrl.yIn) yVal <= busVal;
        if (ctrl.zIn) z <= aluResult;  // Z takes the ALU result, not the bus.
    end

endmodule

// ==== controlUnit.sv ====
`timescale 1ns/1ps
module controlUnit (
    input  logic clk,
    input  logic rstN,
    input  cpuPkg::instrWord instr,
    input  logic memDone,
    output cpuPkg::ctrlSignals ctrl,
    output logic halted
);
    import cpuPkg::*;

    typedef enum logic [3:0] {
        t0,
        t1,
        t2,
        t3,
        t4,
        t5,
        t6,
        t7,
        tHalt
    } stateT;

    stateT state;
    stateT nextState;
    opcodeT opcode;
    logic isLd;
    logic isMem;
    logic isImm;
    logic isReg;
    logic [regCount-1:0] raSel;
    logic [regCount-1:0] rbSel;
    logic [regCount-1:0] rcSel;
    aluOpT decodedOp;

    assign opcode = instr.rFmt.opcode;
    assign isLd = (opcode == opLd);
    assign isMem = isLd || (opcode == opSt);
    assign isImm = opcode inside {opAddi, opAndi, opOri};
    assign isReg = opcode inside {opAdd, opSub, opAnd, opOr, opShr, opShl};
    assign halted = (state == tHalt);

    always_comb begin
        raSel = '0;
        rbSel = '0;
        rcSel = '0;
        raSel[instr.rFmt.ra] = 1'b1;
        rbSel[instr.rFmt.rb] = 1'b1;
        rcSel[instr.rFmt.rc] = 1'b1;
    end

    // Opcode to ALU operation. Memory ops compute rb plus c.
    always_comb begin
        case (opcode)
            opSub: decodedOp = aluSub;
            opAnd, opAndi: decodedOp = aluAnd;
            opOr, opOri: decodedOp = aluOr;
            opShl: decodedOp = aluShl;
            opShr: decodedOp = aluShr;
            opLd, opSt, opAdd, opAddi: decodedOp = aluAdd;
            default: decodedOp = aluPass;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) state <= t0;
        else state <= nextState;
    end

    always_comb begin
        ctrl = '0;
        ctrl.aluOp = aluPass;
        nextState = state;
        case (state)
            t0: begin
                ctrl.pcOut = 1'b1;
                ctrl.marIn = 1'b1;
                ctrl.zIn = 1'b1;
                ctrl.incPc = 1'b1;
                nextState = t1;
            end
            t1: begin  // Fetch read, PC updated from Z.
                ctrl.zOut = 1'b1;
                ctrl.pcIn = 1'b1;
                ctrl.memRead = 1'b1;
                if (memDone) nextState = t2;
            end
            t2: begin
                ctrl.mdrOut = 1'b1;
                ctrl.irIn = 1'b1;
                nextState = t3;
            end
            t3: begin
                if (opcode == opHalt) begin
                    nextState = tHalt;
                end else if (isReg || isImm || isMem) begin
                    ctrl.regOut = rbSel;
                    ctrl.yIn = 1'b1;
                    nextState = t4;
                end else begin
                    nextState = t0;  // Unknown opcode executes as a no-op.
                end
            end
            t4: begin
                if (isReg) ctrl.regOut = rcSel;
                else ctrl.cOut = 1'b1;
                ctrl.zIn = 1'b1;
                ctrl.aluOp = decodedOp;
                nextState = t5;
            end
            t5: begin
                ctrl.zOut = 1'b1;
                if (isMem) begin
                    ctrl.marIn = 1'b1;  // Effective address.
                    nextState = t6;
                end else begin
                    ctrl.regIn = raSel;
                    nextState = t0;
                end
            end
            t6: begin
                if (isLd) begin
                    ctrl.memRead = 1'b1;
                    if (memDone) nextState = t7;
                end else begin
                    ctrl.regOut = raSel;  // Store data into MDR.
                    ctrl.mdrIn = 1'b1;
                    nextState = t7;
                end
            end
            t7: begin
                if (isLd) begin
                    ctrl.mdrOut = 1'b1;
                    ctrl.regIn = raSel;
                    nextState = t0;
                end else begin
                    ctrl.memWrite = 1'b1;
                    if (memDone) nextState = t0;
                end
            end
            tHalt: begin
                nextState = tHalt;  // Held until reset.
            end
            default: begin
                nextState = t0;
            end
        endcase
    end

endmodule

// ==== cpuPkg.sv ====
package cpuPkg;

    localparam int dataWidth = 32;
    localparam int regCount = 16;
    localparam int regIdxWidth = $clog2(regCount);
    localparam int shiftWidth = $clog2(dataWidth);
    localparam int constWidth = 19;

    typedef enum logic [4:0] {
        opLd   = 5'b00000,
        opSt   = 5'b00010,
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opAnd  = 5'b00101,
        opOr   = 5'b00110,
        opShr  = 5'b00111,
        opShl  = 5'b01000,
        opAddi = 5'b01100,
        opAndi = 5'b01101,
        opOri  = 5'b01110,
        opHalt = 5'b11011
    } opcodeT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluShl,
        aluShr,
        aluPass
    } aluOpT;

    // Three-register form.
    typedef struct packed {
        opcodeT opcode;
        logic [regIdxWidth-1:0] ra;
        logic [regIdxWidth-1:0] rb;
        logic [regIdxWidth-1:0] rc;
        logic [14:0] spare;
    } rFmtT;

    // Register plus signed constant form.
    typedef struct packed {
        opcodeT opcode;
        logic [regIdxWidth-1:0] ra;
        logic [regIdxWidth-1:0] rb;
        logic signed [constWidth-1:0] c;
    } iFmtT;

    typedef union packed {
        rFmtT rFmt;
        iFmtT iFmt;
    } instrWord;

    typedef struct packed {
        logic [regCount-1:0] regIn;   // One-hot.
        logic [regCount-1:0] regOut;  // One-hot.
        logic pcIn;
        logic pcOut;
        logic irIn;
        logic yIn;
        logic zIn;
        logic zOut;
        logic cOut;
        logic marIn;
        logic mdrIn;
        logic mdrOut;
        logic incPc;   // Z gets bus plus 1, Y ignored.
        aluOpT aluOp;
        logic memRead;
        logic memWrite;
    } ctrlSignals;

    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        logic [dataWidth-1:0] adr;
        logic [dataWidth-1:0] datW;
    } wbReq;

    typedef struct packed {
        logic [dataWidth-1:0] datR;
        logic ack;
    } wbRsp;

endpackage

// ==== cpuTb.sv ====
`timescale 1ns/1ps
module cpuTb;
    import cpuPkg::*;

    localparam int memWords = 64;
    localparam int waitLimit = 400;  // Cycles allowed for each wait.
    localparam int quietCycles = 40;

    logic clk;
    logic rstN;
    wbReq wbOut;
    wbRsp wbIn = '0;
    logic halted;

    logic [31:0] mem [memWords];
    int storeCount = 0;
    int testCount = 0;
    int timeoutCount = 0;
    int waitLeft = 0;
    bit pending = 1'b0;

    cpuTop DUT (
        .clk(clk),
        .rstN(rstN),
        .wbOut(wbOut),
        .wbIn(wbIn),
        .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] encodeReg(opcodeT op, logic [3:0] ra,
                                              logic [3:0] rb, logic [3:0] rc);
        return {op, ra, rb, rc, 15'b0};
    endfunction

    function automatic logic [31:0] encodeImm(opcodeT op, logic [3:0] ra,
                                              logic [3:0] rb, int c);
        return {op, ra, rb, c[18:0]};
    endfunction

    // R15 is never written, so it serves as a zero base register.
    task automatic loadProgram();
        for (int i = 0; i < memWords; i++) begin
            mem[i] = 32'hC0DE_0000 + 32'(i);
        end
        mem[0] = encodeImm(opLd, 4, 15, 'h20);
        mem[1] = encodeImm(opLd, 5, 15, 'h21);
        mem[2] = encodeReg(opSub, 0, 4, 5);
        mem[3] = encodeImm(opSt, 0, 15, 'h30);
        mem[4] = encodeReg(opAdd, 1, 4, 5);
        mem[5] = encodeImm(opSt, 1, 15, 'h31);
        mem[6] = encodeReg(opAnd, 2, 4, 5);
        mem[7] = encodeImm(opSt, 2, 15, 'h32);
        mem[8] = encodeReg(opOr, 3, 4, 5);
        mem[9] = encodeImm(opSt, 3, 15, 'h33);
        mem[10] = encodeReg(opShl, 6, 4, 2);  // Shift count from R2.
        mem[11] = encodeImm(opSt, 6, 15, 'h34);
        mem[12] = encodeReg(opShr, 7, 6, 2);
        mem[13] = encodeImm(opSt, 7, 15, 'h35);
        mem[14] = encodeImm(opAddi, 8, 4, -5);
        mem[15] = encodeImm(opSt, 8, 15, 'h36);
        mem[16] = encodeImm(opAndi, 9, 4, -256);
        mem[17] = encodeImm(opSt, 9, 15, 'h37);
        mem[18] = encodeImm(opOri, 10, 5, 'h1200);
        mem[19] = encodeImm(opSt, 10, 15, 'h38);
        mem[20] = {opHalt, 27'b0};
        mem['h20] = 32'h0000_FA92;
        mem['h21] = 32'h0000_00FF;
    endtask

    // Wishbone slave with 0 to 3 wait cycles per transfer.
    always @(negedge clk) begin
        if (wbIn.ack) begin
            wbIn.ack <= 1'b0;
        end else if (wbOut.cyc && wbOut.stb) begin
            if (!pending) begin
                pending = 1'b1;
                waitLeft = $urandom_range(3, 0);
            end
            if (waitLeft == 0) begin
                wbIn.ack <= 1'b1;
                wbIn.datR <= mem[wbOut.adr[5:0]];
                pending = 1'b0;
            end else begin
                waitLeft--;
            end
        end
    end

    // Writes land in memory on the ack edge.
    always @(posedge clk) begin
        if (wbOut.cyc && wbOut.we && wbIn.ack) begin
            mem[wbOut.adr[5:0]] <= wbOut.datW;
            storeCount <= storeCount + 1;
        end
    end

    task automatic awaitFetch(output bit ok);
        int cycles;
        cycles = 0;
        ok = 1'b0;
        while (!ok && cycles < waitLimit) begin
            @(negedge clk);
            cycles++;
            ok = wbOut.cyc;
        end
    endtask

    task automatic awaitStores(input int target, output bit ok);
        int cycles;
        cycles = 0;
        ok = 1'b0;
        while (!ok && cycles < waitLimit) begin
            @(negedge clk);
            cycles++;
            ok = (storeCount >= target);
        end
    endtask

    task automatic awaitHalt(output bit ok);
        int cycles;
        cycles = 0;
        ok = 1'b0;
        while (!ok && cycles < waitLimit) begin
            @(negedge clk);
            cycles++;
            ok = halted;
        end
    endtask

    task automatic reportTest(input string name, input bit ok);
        testCount++;
        if (ok) begin
            $display("test %0d %s: done, assertion failures so far %0d",
                testCount, name, DUT.checks.failCount);
        end else begin
            timeoutCount++;
            $display("test %0d %s: timed out waiting for the event", testCount, name);
        end
    endtask

    initial begin
        bit ok;
        rstN = 1'b0;
        void'($urandom(32'h7170be39));
        loadProgram();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        awaitFetch(ok);
        reportTest("reset then first fetch", ok);
        for (int k = 0; k < 9; k++) begin
            awaitStores(k + 1, ok);
            reportTest($sformatf("store to 0x%0h", 'h30 + k), ok);
        end
        awaitHalt(ok);
        reportTest("halt", ok);
        repeat (quietCycles) @(negedge clk);  // Bus must stay idle here.
        reportTest("no bus cycle after halt", 1'b1);
        $display("tests %0d, timeouts %0d, assertion failures %0d",
            testCount, timeoutCount, DUT.checks.failCount);
        if (timeoutCount == 0 && DUT.checks.failCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== cpuTb_assert.sv ====
`timescale 1ns/1ps
module cpuTbAssert (
    input logic clk,
    input logic rstN,
    input cpuPkg::wbReq wbOut,
    input cpuPkg::wbRsp wbIn,
    input logic halted
);
    import cpuPkg::*;

    // Operands loaded from 0x20 and 0x21.
    localparam logic [31:0] opA = 32'h0000_FA92;
    localparam logic [31:0] opB = 32'h0000_00FF;
    localparam logic [31:0] andVal = opA & opB;
    localparam logic [31:0] shlVal = opA << andVal[4:0];
    localparam logic [31:0] shrVal = shlVal >> andVal[4:0];

    // Immediates after sign extension from 19 bits.
    localparam logic [31:0] addiConst = 32'hFFFF_FFFB;
    localparam logic [31:0] andiConst = 32'hFFFF_FF00;
    localparam logic [31:0] oriConst = 32'h0000_1200;

    // Expected data for the stores to 0x30 up to 0x38.
    localparam logic [31:0] storeTable [9] = '{
        opA - opB,
        opA + opB,
        andVal,
        opA | opB,
        shlVal,
        shrVal,
        opA + addiConst,
        opA & andiConst,
        opB | oriConst
    };

    int failCount = 0;
    logic dataNext;            // Next read is the operand of a ld.
    logic [31:0] nextFetch;
    logic writeAck;
    logic storeInRange;

    assign writeAck = wbOut.cyc && wbOut.we && wbIn.ack;
    assign storeInRange = (wbOut.adr >= 32'h30) && (wbOut.adr <= 32'h38);

    // Follow the read stream to tell fetches from ld operand reads.
    always @(posedge clk) begin
        if (!rstN) begin
            nextFetch <= '0;
            dataNext <= 1'b0;
        end else if (wbOut.cyc && !wbOut.we && wbIn.ack) begin
            if (dataNext) begin
                dataNext <= 1'b0;
            end else begin
                nextFetch <= nextFetch + 32'd1;
                dataNext <= (wbIn.datR[31:27] == opLd);
            end
        end
    end

    resetQuiet: assert property (@(posedge clk)
        !rstN |=> !wbOut.cyc && !wbOut.stb && !halted)
    else begin
        failCount++;
        $error("bus request or halted active during or right after reset");
    end

    stbFollowsCyc: assert property (@(posedge clk) disable iff (!rstN)
        wbOut.stb == wbOut.cyc)
    else begin
        failCount++;
        $error("stb and cyc differ on the Wishbone port");
    end

    // A request stays open and unchanged until the slave acks.
    requestHeld: assert property (@(posedge clk) disable iff (!rstN)
        (wbOut.stb && !wbIn.ack) |=> wbOut.stb && $stable(wbOut.adr) &&
        $stable(wbOut.we) && (!wbOut.we || $stable(wbOut.datW)))
    else begin
        failCount++;
        $error("Wishbone request changed or dropped before ack");
    end

    fetchOrder: assert property (@(posedge clk) disable iff (!rstN)
        (wbOut.cyc && !wbOut.we && !dataNext) |-> wbOut.adr == nextFetch)
    else begin
        failCount++;
        $error("ERR %0t wbOut.adr got %h expected %h", $time,
            $sampled(wbOut.adr), $sampled(nextFetch));
    end

    storeAddress: assert property (@(posedge clk) disable iff (!rstN)
        writeAck |-> storeInRange)
    else begin
        failCount++;
        $error("store went to an address outside 0x30 to 0x38");
    end

    storeData: assert property (@(posedge clk) disable iff (!rstN)
        (writeAck && storeInRange) |-> wbOut.datW == storeTable[wbOut.adr[3:0]])
    else begin
        failCount++;
        $error("ERR %0t wbOut.datW got %h expected %h", $time,
            $sampled(wbOut.datW), storeTable[$sampled(wbOut.adr[3:0])]);
    end

    haltNoBus: assert property (@(posedge clk) disable iff (!rstN)
        halted |-> !wbOut.cyc)
    else begin
        failCount++;
        $error("Wishbone cycle started while halted");
    end

    haltHeld: assert property (@(posedge clk) disable iff (!rstN)
        halted |=> halted)
    else begin
        failCount++;
        $error("halted dropped without a reset");
    end

endmodule

bind cpuTop cpuTbAssert checks (
    .clk(clk),
    .rstN(rstN),
    .wbOut(wbOut),
    .wbIn(wbIn),
    .halted(halted)
);

// ==== cpuTop.sv ====
`timescale 1ns/1ps
module cpuTop (
    input  logic clk,
    input  logic rstN,
    output cpuPkg::wbReq wbOut,
    input  cpuPkg::wbRsp wbIn,
    output logic halted
);
    import cpuPkg::*;

    ctrlSignals ctrl;
    instrWord instr;
    logic memDone;
    logic [dataWidth-1:0] busVal;
    logic [dataWidth-1:0] yVal;
    logic [dataWidth-1:0] regData;
    logic [dataWidth-1:0] mdrData;
    logic [dataWidth-1:0] aluResult;

    controlUnit control (
        .clk(clk),
        .rstN(rstN),
        .instr(instr),
        .memDone(memDone),
        .ctrl(ctrl),
        .halted(halted)
    );

    regFile regs (
        .clk(clk),
        .rstN(rstN),
        .bus(busVal),
        .regIn(ctrl.regIn),
        .regOut(ctrl.regOut),
        .regData(regData)
    );

    aluUnit alu (
        .yVal(yVal),
        .busVal(busVal),
        .aluOp(ctrl.aluOp),
        .incPc(ctrl.incPc),
        .result(aluResult)
    );

    busRegs datapath (
        .clk(clk),
        .rstN(rstN),
        .ctrl(ctrl),
        .regData(regData),
        .mdrData(mdrData),
        .aluResult(aluResult),
        .busVal(busVal),
        .yVal(yVal),
        .instr(instr)
    );

    memPort mem (
        .clk(clk),
        .rstN(rstN),
        .ctrl(ctrl),
        .busVal(busVal),
        .wbOut(wbOut),
        .wbIn(wbIn),
        .mdrData(mdrData),
        .memDone(memDone)
    );

endmodule

// ==== files.f ====
cpuPkg.sv
regFile.sv
aluUnit.sv
busRegs.sv
memPort.sv
controlUnit.sv
cpuTop.sv
cpuTb_assert.sv
cpuTb.sv

// ==== memPort.sv ====
`timescale 1ns/1ps
module memPort (
    input  logic clk,
    input  logic rstN,
    input  cpuPkg::ctrlSignals ctrl,
    input  logic [cpuPkg::dataWidth-1:0] busVal,
    output cpuPkg::wbReq wbOut,
    input  cpuPkg::wbRsp wbIn,
    output logic [cpuPkg::dataWidth-1:0] mdrData,
    output logic memDone
);
    import cpuPkg::*;

    logic [dataWidth-1:0] mar;
    logic [dataWidth-1:0] mdr;

    // The controller holds its request until memDone, so the cycle
    // stays open with stable address and data until the slave acks.
    always_comb begin
        wbOut.cyc = ctrl.memRead | ctrl.memWrite;
        wbOut.stb = ctrl.memRead | ctrl.memWrite;
        wbOut.we = ctrl.memWrite;
        wbOut.adr = mar;
        wbOut.datW = mdr;
    end

    assign memDone = wbOut.cyc & wbIn.ack;  // One cycle per transfer.
    assign mdrData = mdr;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            mar <= '0;
        end else if (ctrl.marIn) begin
            mar <= busVal;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.mdrIn) begin
            mdr <= busVal;
        end else if (memDone && !wbOut.we) begin
            mdr <= wbIn.datR;  // Read data captured on the ack cycle.
        end
    end

endmodule

// ==== regFile.sv ====
`timescale 1ns/1ps
module regFile (
    input  logic clk,
    input  logic rstN,
    input  logic [cpuPkg::dataWidth-1:0] bus,
    input  logic [cpuPkg::regCount-1:0] regIn,
    input  logic [cpuPkg::regCount-1:0] regOut,
    output logic [cpuPkg::dataWidth-1:0] regData
);
    import cpuPkg::*;

    logic [dataWidth-1:0] regs [regCount];

    // Each register loads the bus when its select bit is set.
    always_ff @(posedge clk) begin
        for (int i = 0; i < regCount; i++) begin
            if (!rstN) begin
                regs[i] <= '0;
            end else if (regIn[i]) begin
                regs[i] <= bus;
            end
        end
    end

    // AND-OR read mux, regOut is one-hot.
    always_comb begin
        regData = '0;
        for (int i = 0; i < regCount; i++) begin
            if (regOut[i]) begin
                regData = regData | regs[i];
            end
        end
    end

endmodule

// ==== runSim.sh ====
#!/usr/bin/env bash
set -euo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module cpuTb
./obj_dir/VcpuTb +verilator+error+limit+1000 | tee sim.log

if grep -q "Checks failed" sim.log; then
    echo "Simulation reported a failure."
    exit 1
fi
echo "Simulation finished without failures."
